/* source/pong_geom_pkg.sv */
// Coordinate type and default field geometry, imported by the blocks that place the ball and bats
`default_nettype none

package pong_geom_pkg;

  // Width of every screen coordinate in the game core
  localparam int coord_w = 11;

  // Unsigned position of the ball or a bat, in field units
  typedef logic [coord_w-1:0] coord_t;

  // Right limit of the field; the ball is out once it reaches it
  localparam coord_t def_field_w = 11'd40;

  // Top and bottom walls
  localparam coord_t def_top_y = 11'd0;
  localparam coord_t def_bottom_y = 11'd30;

  // Bat shape, thickness along x and height along y
  localparam coord_t def_bat_w = 11'd2;
  localparam coord_t def_bat_h = 11'd8;

  // Ball is square
  localparam coord_t def_ball_size = 11'd2;

endpackage

`default_nettype wire

/* source/pong_game_pkg.sv */
// Game-level types shared by the bats, the ball block, the score keeper and the top level
`default_nettype none

package pong_game_pkg;

  import pong_geom_pkg::*;

  // One player's button levels
  typedef struct packed {
    logic up;
    logic down;
  } bat_cmd_t;

  // Ball position and heading, 24 bits
  // dir_x set means moving right, dir_y set means moving down
  typedef struct packed {
    coord_t ball_x;
    coord_t ball_y;
    logic   dir_x;
    logic   dir_y;
  } ball_state_t;

  // Points of one player
  typedef logic [3:0] score_t;

  typedef enum logic {
    player_1,
    player_2
  } player_t;

  // Score keeper FSM
  typedef enum logic [1:0] {
    s_play,
    s_serve,
    s_over
  } score_state_t;

endpackage

`default_nettype wire

/* source/ball_collisions.sv */
// Ball motion with wall and bat bounces and out-of-bounds flag, advanced once per step
`default_nettype none

module ball_collisions
  import pong_geom_pkg::*, pong_game_pkg::*;
#(
  parameter coord_t field_w   = def_field_w,
  parameter coord_t top_y     = def_top_y,
  parameter coord_t bottom_y  = def_bottom_y,
  parameter coord_t bat_w     = def_bat_w,
  parameter coord_t bat_h     = def_bat_h,
  parameter coord_t ball_size = def_ball_size
) (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        step_en,
  input  wire logic        serve,
  input  wire coord_t      p1_y,
  input  wire coord_t      p2_y,
  output ball_state_t      ball,
  output logic             oob
);

  // Serve and reset position
  localparam coord_t centre_x = coord_t'(field_w / 2);
  localparam coord_t centre_y = coord_t'(bottom_y / 2);

  // Left edge of the zone where bat 2 can be hit
  localparam coord_t bat2_x = coord_t'(field_w - bat_w - ball_size);
  localparam coord_t bat_mid = coord_t'(bat_h / 2);

  logic        top_hit;
  logic        bottom_hit;
  logic        p1_hit;
  logic        p2_hit;
  logic        out_now;
  ball_state_t ball_next;

  // Collision tests look at the position held before the step
  always_comb begin
    top_hit    = ball.ball_y <= top_y + ball_size;
    bottom_hit = ball.ball_y >= bottom_y - ball_size;
    p1_hit     = (ball.ball_x <= bat_w) &&
                 (ball.ball_y + ball_size >= p1_y) &&
                 (ball.ball_y <= p1_y + bat_h);
    p2_hit     = (ball.ball_x >= bat2_x) &&
                 (ball.ball_y + ball_size >= p2_y) &&
                 (ball.ball_y <= p2_y + bat_h);
    out_now    = (ball.ball_x == '0) || (ball.ball_x >= field_w);
  end

  always_comb begin
    ball_next = ball;

    // Move with the old heading
    // x stops at zero, so a miss on the left still reads as ball_x == 0
    if (ball.dir_x) begin
      ball_next.ball_x = ball.ball_x + 1'b1;
    end else if (ball.ball_x != '0) begin
      ball_next.ball_x = ball.ball_x - 1'b1;
    end
    if (ball.dir_y) begin
      ball_next.ball_y = ball.ball_y + 1'b1;
    end else begin
      ball_next.ball_y = ball.ball_y - 1'b1;
    end

    // Walls first, then the bats, later rules win
    if (top_hit) begin
      ball_next.dir_y = 1'b1;
    end
    if (bottom_hit) begin
      ball_next.dir_y = 1'b0;
    end

    // Upper half of a bat sends the ball up, lower half sends it down
    if (p1_hit) begin
      ball_next.dir_x = 1'b1;
      ball_next.dir_y = !(ball.ball_y + ball_size <= p1_y + bat_mid);
    end else if (p2_hit) begin
      ball_next.dir_x = 1'b0;
      ball_next.dir_y = !(ball.ball_y + ball_size <= p2_y + bat_mid);
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ball.ball_x <= centre_x;
      ball.ball_y <= centre_y;
      ball.dir_x  <= 1'b1;
      ball.dir_y  <= 1'b1;
      oob         <= 1'b0;
    end else if (serve) begin
      // Relaunch towards the player who just scored
      ball.ball_x <= centre_x;
      ball.ball_y <= centre_y;
      ball.dir_x  <= ~ball.dir_x;
      oob         <= 1'b0;
    end else if (step_en) begin
      ball <= ball_next;
      // Sticky until the next serve
      oob  <= oob | out_now;
    end
  end

endmodule

`default_nettype wire

/* source/bat_control.sv */
// One bat moved by its up and down buttons on each step, kept inside the field walls
`default_nettype none

module bat_control
  import pong_geom_pkg::*, pong_game_pkg::*;
#(
  parameter coord_t top_y    = def_top_y,
  parameter coord_t bottom_y = def_bottom_y,
  parameter coord_t bat_h    = def_bat_h
) (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     step_en,
  input  wire bat_cmd_t cmd,
  output coord_t        bat_y
);

  // Lowest allowed top edge of the bat
  localparam coord_t max_y = coord_t'(bottom_y - bat_h);

  logic   move_up;
  logic   move_down;
  coord_t next_y;

  // Both buttons together cancel out
  assign move_up   = cmd.up && !cmd.down;
  assign move_down = cmd.down && !cmd.up;

  always_comb begin
    next_y = bat_y;
    if (move_up && bat_y > top_y) begin
      next_y = bat_y - 1'b1;
    end else if (move_down && bat_y < max_y) begin
      next_y = bat_y + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      bat_y <= top_y;
    end else if (step_en) begin
      bat_y <= next_y;
    end
  end

endmodule

`default_nettype wire

/* source/score_keeper.sv */
// Score FSM that counts points on out-of-bounds, serves the ball again and stops at the winner
`default_nettype none

module score_keeper
  import pong_game_pkg::*;
#(
  parameter score_t win_score = 4'd3
) (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        step,
  input  wire logic        oob,
  input  wire ball_state_t ball,
  output logic             step_en,
  output logic             serve,
  output score_t           p1_score,
  output score_t           p2_score,
  output logic             game_over,
  output player_t          winner
);

  score_state_t state;
  score_t       p1_next;
  score_t       p2_next;
  logic         left_miss;

  assign p1_next = p1_score + 4'd1;
  assign p2_next = p2_score + 4'd1;

  // Ball left through player 1's side, so the point goes to player 2
  assign left_miss = (ball.ball_x == '0);

  // Steps only reach the bats and ball during play
  assign step_en   = step && (state == s_play);
  assign serve     = (state == s_serve);
  assign game_over = (state == s_over);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= s_play;
      p1_score <= '0;
      p2_score <= '0;
      winner   <= player_1;
    end else begin
      case (state)
        s_play: begin
          if (oob) begin
            if (left_miss) begin
              p2_score <= p2_next;
              if (p2_next == win_score) begin
                state  <= s_over;
                winner <= player_2;
              end else begin
                state <= s_serve;
              end
            end else begin
              p1_score <= p1_next;
              if (p1_next == win_score) begin
                state  <= s_over;
                winner <= player_1;
              end else begin
                state <= s_serve;
              end
            end
          end
        end
        // One cycle of serve, the ball block clears oob on the same edge
        s_serve: state <= s_play;
        // Frozen until reset
        s_over:  state <= s_over;
        default: state <= s_play;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/pong_top.sv */
// Pong game core top level joining both bats, the ball block and the score keeper
`default_nettype none

module pong_top
  import pong_geom_pkg::*, pong_game_pkg::*;
#(
  parameter coord_t field_w   = def_field_w,
  parameter coord_t top_y     = def_top_y,
  parameter coord_t bottom_y  = def_bottom_y,
  parameter coord_t bat_w     = def_bat_w,
  parameter coord_t bat_h     = def_bat_h,
  parameter coord_t ball_size = def_ball_size,
  parameter score_t win_score = 4'd3
) (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     step,
  input  wire bat_cmd_t p1_cmd,
  input  wire bat_cmd_t p2_cmd,
  output ball_state_t   ball,
  output coord_t        p1_y,
  output coord_t        p2_y,
  output score_t        p1_score,
  output score_t        p2_score,
  output logic          oob,
  output logic          game_over,
  output player_t       winner
);

  // Gated step and relaunch pulse from the score keeper
  logic step_en;
  logic serve;

  bat_control #(
    .top_y(top_y), .bottom_y(bottom_y), .bat_h(bat_h)
  ) u_bat_1 (
    .clk(clk), .reset(reset), .step_en(step_en), .cmd(p1_cmd), .bat_y(p1_y)
  );

  bat_control #(
    .top_y(top_y), .bottom_y(bottom_y), .bat_h(bat_h)
  ) u_bat_2 (
    .clk(clk), .reset(reset), .step_en(step_en), .cmd(p2_cmd), .bat_y(p2_y)
  );

  ball_collisions #(
    .field_w(field_w), .top_y(top_y), .bottom_y(bottom_y),
    .bat_w(bat_w), .bat_h(bat_h), .ball_size(ball_size)
  ) u_ball (
    .clk(clk), .reset(reset), .step_en(step_en), .serve(serve),
    .p1_y(p1_y), .p2_y(p2_y), .ball(ball), .oob(oob)
  );

  score_keeper #(
    .win_score(win_score)
  ) u_score (
    .clk(clk), .reset(reset), .step(step), .oob(oob), .ball(ball),
    .step_en(step_en), .serve(serve), .p1_score(p1_score), .p2_score(p2_score),
    .game_over(game_over), .winner(winner)
  );

endmodule

`default_nettype wire

/* testbench/pong_top_asserts.sv */
// Concurrent checks on the ball block, attached to every ball_collisions instance by bind
`default_nettype none

module pong_top_asserts
  import pong_geom_pkg::*, pong_game_pkg::*;
(
  input wire logic        clk,
  input wire logic        reset,
  input wire logic        step_en,
  input wire logic        serve,
  input wire logic        oob,
  input wire logic        top_hit,
  input wire logic        bottom_hit,
  input wire logic        p1_hit,
  input wire logic        p2_hit,
  input wire ball_state_t ball
);

  timeunit 1ns;
  timeprecision 100ps;

  // One unit per axis on each step
  a_move_y: assert property (@(posedge clk) disable iff (reset)
    step_en && !serve |=> (ball.ball_y == $past(ball.ball_y) + 11'd1) ||
                          (ball.ball_y == $past(ball.ball_y) - 11'd1))
    else $error("ball_y did not move by one unit on a step");

  // x parks at zero after a miss on the left
  a_move_x: assert property (@(posedge clk) disable iff (reset)
    step_en && !serve |=> (ball.ball_x == $past(ball.ball_x) + 11'd1) ||
                          (ball.ball_x == $past(ball.ball_x) - 11'd1) ||
                          (ball.ball_x == '0 && $past(ball.ball_x) == '0))
    else $error("ball_x did not move by one unit on a step");

  a_top_wall: assert property (@(posedge clk) disable iff (reset)
    step_en && !serve && top_hit && !bottom_hit && !p1_hit && !p2_hit |=> ball.dir_y)
    else $error("top wall did not send the ball down");

  a_bottom_wall: assert property (@(posedge clk) disable iff (reset)
    step_en && !serve && bottom_hit && !p1_hit && !p2_hit |=> !ball.dir_y)
    else $error("bottom wall did not send the ball up");

  a_oob_hold: assert property (@(posedge clk) disable iff (reset)
    oob && !serve |=> oob)
    else $error("oob dropped without a serve");

  // Serve is a single pulse right after the scoring cycle
  a_serve_timing: assert property (@(posedge clk) disable iff (reset)
    serve |-> $past(oob) && !$past(serve))
    else $error("serve not one cycle after the scoring cycle");

endmodule

bind ball_collisions pong_top_asserts u_asserts (
  .clk(clk), .reset(reset), .step_en(step_en), .serve(serve), .oob(oob),
  .top_hit(top_hit), .bottom_hit(bottom_hit), .p1_hit(p1_hit), .p2_hit(p2_hit),
  .ball(ball)
);

`default_nettype wire

/* testbench/tb_pong_top.sv */
// Testbench for pong_top, runs a table of games against a cycle model and checks every output
`default_nettype none

module tb_pong_top
  import pong_geom_pkg::*, pong_game_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int field_w = 40;
  localparam int top_y = 0;
  localparam int bottom_y = 30;
  localparam int bat_w = 2;
  localparam int bat_h = 8;
  localparam int ball_size = 2;
  localparam int win_score = 3;
  localparam int clk_period = 8;

  typedef enum {mode_idle, mode_random, mode_track, mode_dodge} cmd_mode_t;
  typedef struct {
    string     name;
    int        steps;
    cmd_mode_t mode;
    int        spacing;
    bit        expect_over;
  } test_row_t;

  test_row_t tests[5];
  logic clk, reset, step;
  bat_cmd_t p1_cmd, p2_cmd;
  ball_state_t ball;
  coord_t p1_y, p2_y;
  score_t p1_score, p2_score;
  logic oob, game_over;
  player_t winner;

  // Reference model registers
  ball_state_t m_ball;
  logic m_oob;
  int m_p1_y, m_p2_y, m_p1_score, m_p2_score;
  score_state_t m_state;
  player_t m_winner;
  logic [31:0] lfsr_state;
  bit aim_upper;
  int hits_upper, hits_lower;
  string cur_name;

  pong_top #(
    .field_w(field_w), .top_y(top_y), .bottom_y(bottom_y), .bat_w(bat_w),
    .bat_h(bat_h), .ball_size(ball_size), .win_score(win_score)
  ) dut (
    .clk(clk), .reset(reset), .step(step), .p1_cmd(p1_cmd), .p2_cmd(p2_cmd),
    .ball(ball), .p1_y(p1_y), .p2_y(p2_y), .p1_score(p1_score), .p2_score(p2_score),
    .oob(oob), .game_over(game_over), .winner(winner)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bit(output logic b);
    b = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
  endtask

  function automatic int move_bat(input int y, input bat_cmd_t c);
    if (c.up && !c.down && y > top_y) return y - 1;
    if (c.down && !c.up && y < bottom_y - bat_h) return y + 1;
    return y;
  endfunction

  function automatic bat_cmd_t aim_cmd(input int bat_y, input int target);
    bat_cmd_t c;
    c.up = bat_y > target;
    c.down = bat_y < target;
    return c;
  endfunction

  task automatic choose_cmds(input cmd_mode_t mode, output bat_cmd_t c1, output bat_cmd_t c2);
    int by;
    int target;
    by = m_ball.ball_y;
    c1 = '0;
    c2 = '0;
    if (mode == mode_random) begin
      take_bit(c1.up);
      take_bit(c1.down);
      take_bit(c2.up);
      take_bit(c2.down);
    end else if (mode == mode_track) begin
      // Alternate between meeting the ball with the upper and the lower half
      target = aim_upper ? by + ball_size - 2 : by - 4;
      c1 = aim_cmd(m_p1_y, target);
      c2 = aim_cmd(m_p2_y, target);
    end else if (mode == mode_dodge) begin
      target = (by <= bottom_y / 2) ? bottom_y - bat_h : top_y;
      c1 = aim_cmd(m_p1_y, target);
      c2 = aim_cmd(m_p2_y, target);
    end
  endtask

  task automatic model_reset();
    m_ball.ball_x = coord_t'(field_w / 2);
    m_ball.ball_y = coord_t'(bottom_y / 2);
    m_ball.dir_x = 1'b1;
    m_ball.dir_y = 1'b1;
    m_oob = 1'b0;
    m_p1_y = top_y;
    m_p2_y = top_y;
    m_p1_score = 0;
    m_p2_score = 0;
    m_state = s_play;
    m_winner = player_1;
  endtask

  // One clock edge of the game rules, all from the old register values
  task automatic model_clock(input logic step_in, input bat_cmd_t c1, input bat_cmd_t c2);
    int bx, by, new_score;
    logic step_en, serve, t_hit, b_hit, h1, h2, out_now;
    ball_state_t nb;
    score_state_t ns;
    step_en = step_in && (m_state == s_play);
    serve = (m_state == s_serve);
    bx = m_ball.ball_x;
    by = m_ball.ball_y;
    t_hit = by <= top_y + ball_size;
    b_hit = by >= bottom_y - ball_size;
    h1 = bx <= bat_w && by + ball_size >= m_p1_y && by <= m_p1_y + bat_h;
    h2 = bx >= field_w - bat_w - ball_size && by + ball_size >= m_p2_y &&
         by <= m_p2_y + bat_h;
    out_now = (bx == 0) || (bx >= field_w);
    nb = m_ball;
    nb.ball_x = coord_t'(m_ball.dir_x ? bx + 1 : (bx > 0 ? bx - 1 : 0));
    nb.ball_y = coord_t'(m_ball.dir_y ? by + 1 : by - 1);
    if (t_hit) nb.dir_y = 1'b1;
    if (b_hit) nb.dir_y = 1'b0;
    if (h1) begin
      nb.dir_x = 1'b1;
      nb.dir_y = (by + ball_size > m_p1_y + bat_h / 2);
    end else if (h2) begin
      nb.dir_x = 1'b0;
      nb.dir_y = (by + ball_size > m_p2_y + bat_h / 2);
    end
    if (step_en && (h1 || h2)) begin
      if (nb.dir_y) hits_lower++;
      else hits_upper++;
      aim_upper = !aim_upper;
    end
    ns = m_state;
    if (m_state == s_play && m_oob) begin
      if (bx == 0) begin
        new_score = ++m_p2_score;
        if (new_score == win_score) m_winner = player_2;
      end else begin
        new_score = ++m_p1_score;
        if (new_score == win_score) m_winner = player_1;
      end
      ns = (new_score == win_score) ? s_over : s_serve;
    end else if (m_state == s_serve) begin
      ns = s_play;
    end
    if (serve) begin
      m_ball.ball_x = coord_t'(field_w / 2);
      m_ball.ball_y = coord_t'(bottom_y / 2);
      m_ball.dir_x = ~m_ball.dir_x;
      m_oob = 1'b0;
    end else if (step_en) begin
      m_ball = nb;
      m_oob = m_oob | out_now;
    end
    if (step_en) begin
      m_p1_y = move_bat(m_p1_y, c1);
      m_p2_y = move_bat(m_p2_y, c2);
    end
    m_state = ns;
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s %s expected %0h actual %0h", cur_name, what, expected, actual);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic compare_all();
    check_value("ball", 32'(m_ball), 32'(ball));
    check_value("oob", 32'(m_oob), 32'(oob));
    check_value("p1_y", 32'(m_p1_y), 32'(p1_y));
    check_value("p2_y", 32'(m_p2_y), 32'(p2_y));
    check_value("p1_score", 32'(m_p1_score), 32'(p1_score));
    check_value("p2_score", 32'(m_p2_score), 32'(p2_score));
    check_value("game_over", 32'(m_state == s_over), 32'(game_over));
    check_value("winner", 32'(m_winner), 32'(winner));
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    step = 1'b0;
    p1_cmd = '0;
    p2_cmd = '0;
    model_reset();
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    compare_all();
  endtask

  task automatic run_row(input test_row_t row);
    bat_cmd_t c1, c2;
    logic step_v;
    for (int s = 0; s < row.steps; s++) begin
      for (int c = 0; c < row.spacing; c++) begin
        step_v = (c == 0);
        choose_cmds(row.mode, c1, c2);
        step = step_v;
        p1_cmd = c1;
        p2_cmd = c2;
        @(posedge clk);
        model_clock(step_v, c1, c2);
        #1;
        compare_all();
      end
    end
    step = 1'b0;
  endtask

  initial begin
    longint limit;
    reset = 1'b1;
    step = 1'b0;
    p1_cmd = '0;
    p2_cmd = '0;
    lfsr_state = 32'h55af_b315;
    aim_upper = 1'b1;
    tests[0] = '{"idle_walls", 120, mode_idle, 2, 1'b0};
    tests[1] = '{"serve_drop", 200, mode_idle, 1, 1'b0};
    tests[2] = '{"bat_track", 400, mode_track, 3, 1'b0};
    tests[3] = '{"random_bats", 300, mode_random, 2, 1'b0};
    tests[4] = '{"play_to_win", 900, mode_dodge, 2, 1'b1};
    limit = 1000;
    foreach (tests[i]) limit += (tests[i].steps * tests[i].spacing + 4) * clk_period;
    fork
      begin
        #(limit);
        $display("Watchdog expired, the run did not finish in time");
        $display("test failed");
        $fatal(1);
      end
    join_none
    foreach (tests[i]) begin
      cur_name = tests[i].name;
      hits_upper = 0;
      hits_lower = 0;
      apply_reset();
      run_row(tests[i]);
      if (tests[i].expect_over) check_value("final game_over", 32'd1, 32'(game_over));
      if (tests[i].mode == mode_track && (hits_upper == 0 || hits_lower == 0)) begin
        $display("Test %s did not hit both halves of a bat", cur_name);
        $display("test failed");
        $fatal(1);
      end
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* pong_game.f */
source/pong_geom_pkg.sv
source/pong_game_pkg.sv
source/ball_collisions.sv
source/bat_control.sv
source/score_keeper.sv
source/pong_top.sv
testbench/pong_top_asserts.sv
testbench/tb_pong_top.sv

/* Bender.yml */
package:
  name: pong_game

sources:
  - source/pong_geom_pkg.sv
  - source/pong_game_pkg.sv
  - source/ball_collisions.sv
  - source/bat_control.sv
  - source/score_keeper.sv
  - source/pong_top.sv
  - target: test
    files:
      - testbench/pong_top_asserts.sv
      - testbench/tb_pong_top.sv
